// ==== bus_slave_settings.svh ====
// sizes, id and latency of the serial-bus slave
// BS_MEM_LATENCY must be 1 or more, BS_ADDR_DEPTH a power of two
`ifndef BUS_SLAVE_SETTINGS_SVH
`define BUS_SLAVE_SETTINGS_SVH

// memory geometry
`define BS_ADDR_DEPTH 256
`define BS_DATA_WIDTH 16

// slave addressing on the serial bus
`define BS_ID_WIDTH 2
`define BS_SLAVE_ID 2

// cycles from a read request to its data
`define BS_MEM_LATENCY 2
`define BS_START_PATTERN 3'b111

`endif

// ==== bus_slave_pkg.sv ====
// types shared by the slave blocks, sized from the settings header
`include "bus_slave_settings.svh"

package bus_slave_pkg;

    // start field width, matches BS_START_PATTERN
    localparam int START_BITS = 3;

    typedef logic [$clog2(`BS_ADDR_DEPTH)-1:0] addr_t;
    typedef logic [`BS_DATA_WIDTH-1:0]         data_t;
    typedef logic [`BS_ID_WIDTH-1:0]           slave_id_t;
    typedef logic [$clog2(`BS_DATA_WIDTH):0]   bit_count_t;

    // start | id | r/w | burst | address
    typedef logic [START_BITS+`BS_ID_WIDTH+2+$clog2(`BS_ADDR_DEPTH)-1:0] header_t;
    typedef logic [3:0] hdr_count_t;

    typedef enum logic [1:0] {
        HDR_IDLE,
        HDR_SHIFT,
        HDR_OFFER
    } hdr_state_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_FETCH,
        ENG_READ_SHIFT,
        ENG_WRITE_SHIFT
    } engine_state_t;

endpackage

// ==== bus_slave_ifs.sv ====
// cmd_valid/cmd_ready and mem_req are plain handshakes with no clock of their own
`timescale 1ns/1ps

// decoded command from the header receiver to the engine
interface slave_cmd_if;
    import bus_slave_pkg::*;

    logic  cmd_valid;
    logic  cmd_ready;
    logic  cmd_write;
    logic  cmd_burst;
    addr_t cmd_addr;

    modport source (output cmd_valid, cmd_write, cmd_burst, cmd_addr, input cmd_ready);
    modport sink   (input cmd_valid, cmd_write, cmd_burst, cmd_addr, output cmd_ready);
endinterface

// engine to word memory, reads return after a fixed latency
interface word_mem_if;
    import bus_slave_pkg::*;

    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    data_t mem_rdata;
    logic  mem_rvalid;

    modport master (
        output mem_req, mem_we, mem_addr, mem_wdata,
        input  mem_rdata, mem_rvalid
    );
    modport memory (
        input  mem_req, mem_we, mem_addr, mem_wdata,
        output mem_rdata, mem_rvalid
    );
endinterface

// ==== header_receiver.sv ====
// header bits arrive MSB first on consecutive cycles, no gaps allowed
// a new header is only accepted while the engine is idle
`timescale 1ns/1ps
`include "bus_slave_settings.svh"

module header_receiver (
    input  logic        clk,
    input  logic        rstN,
    input  logic        control,
    slave_cmd_if.source cmd
);
    import bus_slave_pkg::*;

    localparam int HDR_BITS  = $bits(header_t);
    localparam int ADDR_W    = $bits(addr_t);
    localparam int ID_W      = $bits(slave_id_t);
    // field positions in the shifted header
    localparam int BURST_POS = ADDR_W;
    localparam int RW_POS    = ADDR_W + 1;
    localparam int ID_LSB    = ADDR_W + 2;
    localparam int START_LSB = ID_LSB + ID_W;
    localparam hdr_count_t LAST_COUNT = hdr_count_t'(HDR_BITS - 1);

    hdr_state_t state;
    header_t    hdr;
    hdr_count_t hdr_count;
    logic       take_bit;
    logic       start_ok;
    logic       id_ok;

    // first start bit only counts while the engine can take a command
    assign take_bit = (state == HDR_SHIFT) ||
                      (state == HDR_IDLE && control && cmd.cmd_ready);

    assign start_ok = (hdr[HDR_BITS-1:START_LSB] == `BS_START_PATTERN);
    assign id_ok    = (hdr[START_LSB-1:ID_LSB] == slave_id_t'(`BS_SLAVE_ID));

    // fields stay put while offered, hdr does not shift in OFFER
    assign cmd.cmd_valid = (state == HDR_OFFER) && start_ok && id_ok;
    assign cmd.cmd_write = hdr[RW_POS];
    assign cmd.cmd_burst = hdr[BURST_POS];
    assign cmd.cmd_addr  = hdr[ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (take_bit) begin
            hdr <= {hdr[HDR_BITS-2:0], control};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= HDR_IDLE;
            hdr_count <= '0;
        end else begin
            case (state)
                HDR_IDLE: begin
                    if (take_bit) begin
                        hdr_count <= hdr_count_t'(1);
                        state     <= HDR_SHIFT;
                    end
                end
                HDR_SHIFT: begin
                    hdr_count <= hdr_count + 1'b1;
                    if (hdr_count == LAST_COUNT) begin
                        state <= HDR_OFFER;
                    end
                end
                HDR_OFFER: begin
                    // bad start or id is dropped without a handshake
                    if (!(start_ok && id_ok) || cmd.cmd_ready) begin
                        state <= HDR_IDLE;
                    end
                end
                default: state <= HDR_IDLE;
            endcase
        end
    end

endmodule

// ==== transfer_engine.sv ====
// one bit per cycle with valid && ready, MSB first in both directions
// a burst continues word by word until last is seen on a word's final bit
`timescale 1ns/1ps

module transfer_engine (
    input  logic       clk,
    input  logic       rstN,
    input  logic       wd,
    input  logic       valid,
    input  logic       last,
    output logic       rd,
    output logic       ready,
    slave_cmd_if.sink  cmd,
    word_mem_if.master mem
);
    import bus_slave_pkg::*;

    localparam int DATA_W = $bits(data_t);
    localparam bit_count_t LAST_BIT = bit_count_t'(DATA_W - 1);

    engine_state_t state;
    addr_t         addr;
    data_t         shreg;
    bit_count_t    bit_cnt;
    logic          burst;
    logic          wr_pending;
    logic          fetch_wait;
    logic          cmd_take;
    logic          xfer;
    logic          word_end;
    logic          fetch_req;
    logic          next_read;

    // only a fetch holds the master off
    assign ready    = (state != ENG_FETCH);
    assign xfer     = valid && ready;
    assign word_end = xfer && (bit_cnt == LAST_BIT);

    assign cmd.cmd_ready = (state == ENG_IDLE);
    assign cmd_take      = cmd.cmd_valid && cmd.cmd_ready;

    // one request per fetch, then wait for the data to come back
    assign fetch_req = (state == ENG_FETCH) && !fetch_wait;
    assign next_read = (state == ENG_READ_SHIFT) && word_end && burst && !last;

    // a finished write word sits in shreg for exactly one cycle,
    // the memory samples it on the same edge the next bit shifts in
    assign mem.mem_req   = fetch_req || wr_pending;
    assign mem.mem_we    = wr_pending;
    assign mem.mem_addr  = addr;
    assign mem.mem_wdata = shreg;

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            addr <= cmd.cmd_addr;
        end else if (wr_pending || next_read) begin
            addr <= addr + 1'b1;
        end

        if (state == ENG_FETCH && mem.mem_rvalid) begin
            shreg <= mem.mem_rdata;
        end else if (state == ENG_READ_SHIFT && xfer) begin
            shreg <= shreg << 1;
        end else if (state == ENG_WRITE_SHIFT && xfer) begin
            shreg <= {shreg[DATA_W-2:0], wd};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= ENG_IDLE;
            bit_cnt    <= '0;
            burst      <= 1'b0;
            wr_pending <= 1'b0;
            fetch_wait <= 1'b0;
            rd         <= 1'b0;
        end else begin
            wr_pending <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (cmd_take) begin
                        burst   <= cmd.cmd_burst;
                        bit_cnt <= '0;
                        state   <= cmd.cmd_write ? ENG_WRITE_SHIFT : ENG_FETCH;
                    end
                end
                ENG_FETCH: begin
                    if (fetch_req) begin
                        fetch_wait <= 1'b1;
                    end
                    if (mem.mem_rvalid) begin
                        fetch_wait <= 1'b0;
                        rd         <= mem.mem_rdata[DATA_W-1];
                        state      <= ENG_READ_SHIFT;
                    end
                end
                ENG_READ_SHIFT: begin
                    // rd holds while valid is low
                    if (xfer) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        rd      <= shreg[DATA_W-2];
                    end
                    if (word_end) begin
                        bit_cnt <= '0;
                        rd      <= 1'b0;
                        state   <= next_read ? ENG_FETCH : ENG_IDLE;
                    end
                end
                ENG_WRITE_SHIFT: begin
                    if (xfer) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (word_end) begin
                        bit_cnt    <= '0;
                        wr_pending <= 1'b1;
                        if (!burst || last) begin
                            state <= ENG_IDLE;
                        end
                    end
                end
                default: state <= ENG_IDLE;
            endcase
        end
    end

endmodule

// ==== word_memory.sv ====
// contents start at zero, no file load
// read data appears BS_MEM_LATENCY cycles after the request, writes land at once
`timescale 1ns/1ps
`include "bus_slave_settings.svh"

module word_memory (
    input  logic        clk,
    input  logic        rstN,
    word_mem_if.memory  mem
);
    import bus_slave_pkg::*;

    localparam int LAT = `BS_MEM_LATENCY;

    data_t      ram [`BS_ADDR_DEPTH] = '{default: '0};
    data_t      rdata_pipe [LAT];
    logic [LAT-1:0] rvalid_pipe;
    logic       rd_req;

    assign rd_req = mem.mem_req && !mem.mem_we;

    always_ff @(posedge clk) begin
        if (mem.mem_req && mem.mem_we) begin
            ram[mem.mem_addr] <= mem.mem_wdata;
        end
        // data stages run freely, rvalid marks the useful ones
        rdata_pipe[0] <= ram[mem.mem_addr];
        for (int i = 1; i < LAT; i++) begin
            rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rvalid_pipe <= '0;
        end else begin
            rvalid_pipe[0] <= rd_req;
            for (int i = 1; i < LAT; i++) begin
                rvalid_pipe[i] <= rvalid_pipe[i-1];
            end
        end
    end

    assign mem.mem_rdata  = rdata_pipe[LAT-1];
    assign mem.mem_rvalid = rvalid_pipe[LAT-1];

endmodule

// ==== bus_slave_top.sv ====
// serial-bus slave, one id per instance, set in the settings header
`timescale 1ns/1ps

module bus_slave_top (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wd,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready
);

    slave_cmd_if cmd_if ();
    word_mem_if  mem_if ();

    // header decode steers the engine
    header_receiver i_header_receiver (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .cmd     (cmd_if.source)
    );

    transfer_engine i_transfer_engine (
        .clk   (clk),
        .rstN  (rstN),
        .wd    (wd),
        .valid (valid),
        .last  (last),
        .rd    (rd),
        .ready (ready),
        .cmd   (cmd_if.sink),
        .mem   (mem_if.master)
    );

    word_memory i_word_memory (
        .clk  (clk),
        .rstN (rstN),
        .mem  (mem_if.memory)
    );

endmodule

// ==== bus_slave_asserts.sv ====
// bound into bus_slave_top, looks at the internal command and memory handshakes
`timescale 1ns/1ps
`include "bus_slave_settings.svh"

module bus_slave_asserts (
    input logic clk,
    input logic rstN,
    input logic cmd_valid,
    input logic cmd_ready,
    input logic mem_req,
    input logic mem_we,
    input logic mem_rvalid,
    input logic ready
);

    int fail_count = 0;

    // an offered command stays up until the engine takes it
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rstN)
        cmd_valid && !cmd_ready |=> cmd_valid)
        else begin
            $error("command offer dropped before the engine took it");
            fail_count++;
        end

    a_read_latency: assert property (@(posedge clk) disable iff (!rstN)
        mem_req && !mem_we |-> ##`BS_MEM_LATENCY mem_rvalid)
        else begin
            $error("read data did not return after the memory latency");
            fail_count++;
        end

    a_no_stray_rvalid: assert property (@(posedge clk) disable iff (!rstN)
        mem_rvalid |-> $past(mem_req && !mem_we, `BS_MEM_LATENCY))
        else begin
            $error("read data valid without a matching request");
            fail_count++;
        end

    // cmd_ready is high exactly while the engine is idle
    a_idle_ready: assert property (@(posedge clk) disable iff (!rstN)
        cmd_ready |-> ready)
        else begin
            $error("ready low while the engine is idle");
            fail_count++;
        end

endmodule

bind bus_slave_top bus_slave_asserts i_asserts (
    .clk        (clk),
    .rstN       (rstN),
    .cmd_valid  (cmd_if.cmd_valid),
    .cmd_ready  (cmd_if.cmd_ready),
    .mem_req    (mem_if.mem_req),
    .mem_we     (mem_if.mem_we),
    .mem_rvalid (mem_if.mem_rvalid),
    .ready      (ready)
);

// ==== bus_slave_checker.sv ====
// watches the serial port of the slave, expected read words are queued per test
// rd, ready and valid are sampled together on the rising edge
`timescale 1ns/1ps

module bus_slave_checker (
    input logic clk,
    input logic rstN,
    input logic rd,
    input logic ready,
    input logic valid
);
    import bus_slave_pkg::*;

    localparam int DATA_W = $bits(data_t);

    // set from the testbench tasks
    string cur_name = "none";
    data_t exp_words [16];
    int    exp_count = 0;
    int    test_seq = 0;
    int    task_errors = 0;
    int    start_errors = 0;
    int    test_count = 0;
    int    failed_tests = 0;

    // owned by the monitor process
    int    seen_seq = 0;
    int    word_idx = 0;
    int    got_bits = 0;
    data_t got_word = '0;
    int    watch_errors = 0;
    logic  hold_armed = 1'b0;
    logic  hold_rd = 1'b0;

    function automatic int total_errors();
        return task_errors + watch_errors;
    endfunction

    task automatic begin_test(input string name);
        cur_name = name;
        exp_count = 0;
        start_errors = total_errors();
        test_seq++;
    endtask

    task automatic expect_word(input data_t w);
        if (exp_count < 16) begin
            exp_words[exp_count] = w;
            exp_count++;
        end
    endtask

    task automatic count_failure();
        task_errors++;
    endtask

    task automatic check_reset();
        if (ready !== 1'b1) begin
            $display("CHECK FAILED %s ready: expected 1, actual %b", cur_name, ready);
            task_errors++;
        end
        if (rd !== 1'b0) begin
            $display("CHECK FAILED %s rd: expected 0, actual %b", cur_name, rd);
            task_errors++;
        end
    endtask

    task automatic end_test();
        int received;
        int errs;
        received = (seen_seq == test_seq) ? word_idx : 0;
        if (received < exp_count) begin
            $display("ERROR: test %s got only %0d of %0d read words", cur_name, received,
                     exp_count);
            task_errors++;
        end
        errs = total_errors() - start_errors;
        test_count++;
        if (errs == 0) begin
            $display("test %s: ok", cur_name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", cur_name, errs);
        end
    endtask

    task automatic report();
        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, total_errors());
    endtask

    always @(posedge clk) begin
        // a new test restarts word collection
        if (seen_seq != test_seq) begin
            seen_seq = test_seq;
            word_idx = 0;
            got_bits = 0;
        end
        if (!rstN) begin
            hold_armed = 1'b0;
        end else begin
            // no transfer last edge, so rd must not have moved
            if (hold_armed && rd !== hold_rd) begin
                $display("CHECK FAILED %s rd during stall: expected %b, actual %b",
                         cur_name, hold_rd, rd);
                watch_errors++;
            end
            hold_armed = ready && !valid;
            hold_rd = rd;
            if (ready && valid && word_idx < exp_count) begin
                got_word = {got_word[DATA_W-2:0], rd};
                got_bits++;
                if (got_bits == DATA_W) begin
                    if (got_word !== exp_words[word_idx]) begin
                        $display("CHECK FAILED %s word %0d: expected %h, actual %h",
                                 cur_name, word_idx, exp_words[word_idx], got_word);
                        watch_errors++;
                    end
                    word_idx++;
                    got_bits = 0;
                end
            end
        end
    end

endmodule

// ==== tb_bus_slave.sv ====
// runs a table of bus transactions against the slave, valid drops at random
// good rows use the id and start pattern from the settings header
`timescale 1ns/1ps
`include "bus_slave_settings.svh"

module tb_bus_slave;
    import bus_slave_pkg::*;

    typedef struct packed {
        logic       write;
        logic       burst;
        logic [2:0] start;
        slave_id_t  id;
        addr_t      addr;
        logic [3:0] count;
        data_t      first;
    } row_t;

    localparam int DATA_W = $bits(data_t);
    localparam logic [2:0] GOOD_START = `BS_START_PATTERN;
    localparam slave_id_t MY_ID = slave_id_t'(`BS_SLAVE_ID);
    localparam slave_id_t WRONG_ID = slave_id_t'(`BS_SLAVE_ID + 1);

    logic clk;
    logic rstN;
    logic control;
    logic wd;
    logic valid;
    logic last;
    logic rd;
    logic ready;

    row_t   rows[$];
    string  names[$];
    data_t  model [`BS_ADDR_DEPTH];
    data_t  words [16];
    integer seed = 32'h1927_d8eb;
    int     assert_fails;

    bus_slave_top i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wd      (wd),
        .valid   (valid),
        .last    (last),
        .rd      (rd),
        .ready   (ready)
    );

    bus_slave_checker i_checker (
        .clk   (clk),
        .rstN  (rstN),
        .rd    (rd),
        .ready (ready),
        .valid (valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_row(
        input string      name,
        input logic       write,
        input logic       burst,
        input logic [2:0] start,
        input slave_id_t  id,
        input addr_t      addr,
        input int         count,
        input data_t      first
    );
        names.push_back(name);
        rows.push_back({write, burst, start, id, addr, 4'(count), first});
    endtask

    task automatic send_header(input row_t r);
        header_t hdr;
        hdr = {r.start, r.id, r.write, r.burst, r.addr};
        for (int i = $bits(header_t) - 1; i >= 0; i--) begin
            @(negedge clk);
            control = hdr[i];
        end
        // decode cycle, the engine takes the command at its end
        @(negedge clk);
        control = 1'b0;
    endtask

    // one bit moves on each edge that sees ready and valid high
    task automatic move_bits(input string name, input row_t r);
        int   total;
        int   done;
        int   waited;
        logic go;
        total = r.count * DATA_W;
        done = 0;
        waited = 0;
        while (done < total && waited < total * 8 + 64) begin
            @(negedge clk);
            go = ($random(seed) % 4) != 0;
            valid = go;
            wd = r.write ? words[done / DATA_W][DATA_W - 1 - done % DATA_W] : 1'b0;
            last = (done == total - 1);
            if (ready && go) begin
                done++;
            end
            waited++;
        end
        @(negedge clk);
        valid = 1'b0;
        last = 1'b0;
        wd = 1'b0;
        if (done < total) begin
            $display("ERROR: test %s timed out after %0d of %0d bit transfers", name, done,
                     total);
            i_checker.count_failure();
        end
    endtask

    task automatic run_row(input string name, input row_t r);
        logic good;
        good = (r.start == GOOD_START) && (r.id == MY_ID);
        i_checker.begin_test(name);
        words[0] = r.first;
        for (int i = 1; i < r.count; i++) begin
            words[i] = data_t'($random(seed));
        end
        for (int i = 0; i < r.count; i++) begin
            if (r.write && good) begin
                model[addr_t'(r.addr + i)] = words[i];
            end else if (!r.write && good) begin
                i_checker.expect_word(model[addr_t'(r.addr + i)]);
            end
        end
        send_header(r);
        move_bits(name, r);
        // bus gap before the next header
        repeat (3) @(negedge clk);
        i_checker.end_test();
    endtask

    initial begin
        rstN = 1'b0;
        control = 1'b0;
        wd = 1'b0;
        valid = 1'b0;
        last = 1'b0;
        for (int a = 0; a < `BS_ADDR_DEPTH; a++) begin
            model[a] = '0;
        end

        // name, write, burst, start, id, addr, words, first word
        add_row("single_wr",      1'b1, 1'b0, GOOD_START, MY_ID,    8'h10, 1, 16'ha5c3);
        add_row("single_rd",      1'b0, 1'b0, GOOD_START, MY_ID,    8'h10, 1, 16'h0000);
        add_row("burst_wr",       1'b1, 1'b1, GOOD_START, MY_ID,    8'h40, 4, 16'h1234);
        add_row("burst_rd",       1'b0, 1'b1, GOOD_START, MY_ID,    8'h40, 4, 16'h0000);
        add_row("wrong_id_wr",    1'b1, 1'b0, GOOD_START, WRONG_ID, 8'h10, 1, 16'hdead);
        add_row("wrong_id_rd",    1'b0, 1'b0, GOOD_START, MY_ID,    8'h10, 1, 16'h0000);
        add_row("wrong_start_wr", 1'b1, 1'b0, 3'b110,     MY_ID,    8'h40, 1, 16'hbeef);
        add_row("wrong_start_rd", 1'b0, 1'b0, GOOD_START, MY_ID,    8'h40, 1, 16'h0000);
        // long burst that wraps the address
        add_row("long_burst_wr",  1'b1, 1'b1, GOOD_START, MY_ID,    8'hfc, 8, 16'h0f0f);
        add_row("long_burst_rd",  1'b0, 1'b1, GOOD_START, MY_ID,    8'hfc, 8, 16'h0000);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        i_checker.begin_test("reset_state");
        i_checker.check_reset();
        i_checker.end_test();

        for (int n = 0; n < rows.size(); n++) begin
            run_row(names[n], rows[n]);
        end

        i_checker.report();
        assert_fails = i_dut.i_asserts.fail_count;
        if (i_checker.total_errors() == 0 && assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
bus_slave_pkg.sv
bus_slave_ifs.sv
header_receiver.sv
transfer_engine.sv
word_memory.sv
bus_slave_top.sv
bus_slave_asserts.sv
bus_slave_checker.sv
tb_bus_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds with Verilator and runs the testbench, pass means the pass message was printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
    --top-module tb_bus_slave -o sim_bus_slave ||
{ echo "build failed"; exit 1; }
out=$(./obj_dir/sim_bus_slave +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "Result: PASSED" && echo "simulation ok" || { echo "simulation failed"; exit 1; }
